/* include/character_defines.svh */
`ifndef CHARACTER_DEFINES_SVH
`define CHARACTER_DEFINES_SVH

// word widths
`define COORD_W      10   // screen coordinate
`define VEL_W        5    // signed vertical speed

// screen limits and start point
`define X_LIMIT      639  // last visible column
`define Y_LIMIT      479  // last visible row, below it the character is lost
`define X_START      40
`define Y_START      400
`define X_STEP       2    // pixels per frame while walking

// level geometry, one flat floor with one gap in it
`define FLOOR_Y      440
`define PIT_X_LO     300
`define PIT_X_HI     340

// half extents of the boxes
`define HALF_W       10   // same for the character and every object
`define SIZE_SMALL   10   // half height, normal body
`define SIZE_BIG     20   // half height after the red upgrade

// vertical speeds, negative is up
`define JUMP_VEL     (-5)
`define BOUNCE_VEL   (-3)
`define FALL_MAX     4

// frame dividers on the delay counter
`define WALK_DIV     5
`define GRAV_DIV     10
`define RESPAWN_DIV  250
`define DELAY_WRAP   500

`define LIVES_INIT   2
`define N_OBJ        4    // enemy, piranha, red, green

`endif

/* logic/character_pkg.sv */
`include "character_defines.svh"

package character_pkg;

	typedef logic [`COORD_W-1:0] coord_t;      // one screen coordinate
	typedef logic signed [`VEL_W-1:0] vel_t;   // pixels per frame, up is negative

	// centre of a sprite
	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// edges of a hitbox, inclusive
	typedef struct packed {
		coord_t left;
		coord_t right;
		coord_t top;
		coord_t bottom;
	} box_t;

	typedef struct packed {
		logic side;    // overlap on both axes
		logic stomp;   // landing on top of the object
	} contact_t;

	// per frame events from the objects
	typedef struct packed {
		logic hurt;
		logic bounce;
		logic power_up;
		logic extra_life;
	} events_t;

	typedef struct packed {
		logic walk_tick;
		logic grav_tick;
		logic respawn_tick;
	} ticks_t;

	typedef struct packed {
		logic up;
		logic left;
		logic right;
	} keys_t;

	// values double as the object index
	typedef enum logic [1:0] {
		ROLE_ENEMY   = 2'd0,
		ROLE_PIRANHA = 2'd1,
		ROLE_RED     = 2'd2,
		ROLE_GREEN   = 2'd3
	} obj_role_e;

endpackage

/* logic/hitbox_builder.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module hitbox_builder
(
	input  character_pkg::point_t pos,                 // character centre
	input  character_pkg::coord_t size,                // character half height
	input  character_pkg::point_t objects [`N_OBJ],    // object centres, role order
	output character_pkg::box_t   char_box,
	output character_pkg::box_t   obj_box [`N_OBJ]
);
	import character_pkg::*;

	// inverted edges, can never overlap a real box
	localparam box_t EMPTY_BOX = '{left: '1, right: '0, top: '1, bottom: '0};

	function automatic box_t make_box(input point_t c, input coord_t half_x, input coord_t half_y);
		box_t b;
		logic [`COORD_W:0] far_x;   // one bit wider so the sum can not wrap
		logic [`COORD_W:0] far_y;
		far_x = {1'b0, c.x} + {1'b0, half_x};
		far_y = {1'b0, c.y} + {1'b0, half_y};
		if (c.x < half_x || c.y < half_y)            // past left or top edge
			b = EMPTY_BOX;
		else if (far_x > `X_LIMIT || far_y > `Y_LIMIT) // past right or bottom edge
			b = EMPTY_BOX;
		else
		begin
			b.left   = c.x - half_x;
			b.right  = c.x + half_x;
			b.top    = c.y - half_y;
			b.bottom = c.y + half_y;
		end
		return b;
	endfunction

	always_comb
	begin
		char_box = make_box(pos, coord_t'(`HALF_W), size);  // body height follows the upgrade
		for (int i = 0; i < `N_OBJ; i++)
			obj_box[i] = make_box(objects[i], coord_t'(`HALF_W), coord_t'(`HALF_W));
	end

endmodule

/* logic/object_contact.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module object_contact
(
	input  character_pkg::box_t     char_box,
	input  character_pkg::box_t     obj_box,
	input  logic                    airborne,   // character not standing on the floor
	output character_pkg::contact_t contact
);

	logic              x_ovl;    // edges cross horizontally
	logic              y_ovl;    // edges cross vertically
	logic              above;    // feet no lower than the object top
	logic              near;     // feet close enough to count as a stomp
	logic [`COORD_W:0] reach;    // feet plus the stomp window, no wrap
	logic              stomp;

	// inclusive edges on both boxes
	assign x_ovl = (char_box.left <= obj_box.right) && (char_box.right >= obj_box.left);
	assign y_ovl = (char_box.top <= obj_box.bottom) && (char_box.bottom >= obj_box.top);

	assign reach = {1'b0, char_box.bottom} + (`HALF_W + 1);
	assign above = char_box.bottom <= obj_box.top;
	assign near  = reach >= {1'b0, obj_box.top};

	// only a falling or jumping character can land on something
	assign stomp = x_ovl && airborne && above && near;

	assign contact.stomp = stomp;
	assign contact.side  = x_ovl && y_ovl && !stomp;  // stomp wins on the shared row

endmodule

/* logic/contact_resolver.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module contact_resolver
(
	input  character_pkg::contact_t contact [`N_OBJ],  // one result per object
	input  logic                    on_ground,
	input  logic                    alive,
	output character_pkg::events_t  events
);
	import character_pkg::*;

	contact_t enemy;
	contact_t piranha;
	contact_t red;
	contact_t green;
	events_t  raw;      // events before the death mask

	// pick each object by its role
	assign enemy   = contact[ROLE_ENEMY];
	assign piranha = contact[ROLE_PIRANHA];
	assign red     = contact[ROLE_RED];
	assign green   = contact[ROLE_GREEN];

	always_comb
	begin
		// enemy only bites a walking character, the piranha from any side
		raw.hurt       = (enemy.side && on_ground) || piranha.side || piranha.stomp;
		raw.bounce     = enemy.stomp;                 // landed on the enemy
		raw.power_up   = red.side || red.stomp;       // any touch collects
		raw.extra_life = green.side || green.stomp;
	end

	// a dead character ignores everything
	assign events = alive ? raw : '0;

endmodule

/* logic/frame_timer.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module frame_timer
(
	input  logic                  reset,      // frame strobe
	input  logic                  frame_clk,  // async clear
	input  logic                  run,
	input  logic                  respawn,
	output character_pkg::ticks_t ticks
);

	logic [$clog2(`DELAY_WRAP+1)-1:0] delay;  // animation delay, one count per frame

	always_ff @(posedge reset or posedge frame_clk)
	begin
		if (frame_clk)
			delay <= '0;
		else if (run || respawn)         // restart the animation phase
			delay <= '0;
		else if (delay >= `DELAY_WRAP)  // 500 is the last count
			delay <= '0;
		else
			delay <= delay + 1'b1;
	end

	// ticks are high on every multiple of their divider
	assign ticks.walk_tick    = (delay % `WALK_DIV) == 0;
	assign ticks.grav_tick    = (delay % `GRAV_DIV) == 0;
	assign ticks.respawn_tick = (delay % `RESPAWN_DIV) == 0;  // hits 0, 250 and 500

endmodule

/* logic/motion_ctrl.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module motion_ctrl
(
	input  logic                  reset,       // frame strobe
	input  logic                  frame_clk,   // async clear
	input  logic                  run,
	input  logic                  respawn,
	input  character_pkg::keys_t  keys,
	input  character_pkg::ticks_t ticks,
	input  character_pkg::events_t events,
	input  logic                  alive,
	input  character_pkg::coord_t size,        // half height of the body
	output character_pkg::point_t pos,
	output character_pkg::vel_t   vel,
	output logic                  on_ground,
	output logic                  is_walking,
	output logic [1:0]            walk_count,  // walk animation frame
	output logic                  direction    // 1 faces right
);
	import character_pkg::*;

	localparam point_t START   = '{x: coord_t'(`X_START), y: coord_t'(`Y_START)};
	localparam coord_t STEP    = coord_t'(`X_STEP);
	localparam vel_t   VEL_CAP = vel_t'(`FALL_MAX);

	coord_t     vel_ext;     // velocity widened with its sign
	coord_t     y_step;      // y moved by this frame's velocity
	coord_t     floor_top;   // centre y with the feet on the floor
	logic       over_floor;  // not above the pit
	point_t     pos_next;
	vel_t       vel_next;
	logic       on_ground_next;
	logic       is_walking_next;
	logic [1:0] walk_count_next;
	logic       direction_next;

	// gravity, -5 -3 -1 0 then +2 up to the cap
	function automatic vel_t fall_step(input vel_t v);
		vel_t n;
		n = v + vel_t'(2);
		if (v < 0 && n > 0)        // -1 rests at 0 for one tick
			n = '0;
		else if (n > VEL_CAP)
			n = VEL_CAP;
		return n;
	endfunction

	// death hop, a kick up from rest then the same climb to the cap
	function automatic vel_t hop_step(input vel_t v);
		vel_t n;
		if (v == '0)
			n = vel_t'(`JUMP_VEL);
		else
		begin
			n = v + vel_t'(2);
			if (n > VEL_CAP)
				n = VEL_CAP;
		end
		return n;
	endfunction

	assign vel_ext    = {{(`COORD_W-`VEL_W){vel[`VEL_W-1]}}, vel};
	assign y_step     = pos.y + vel_ext;  // wraps like the velocity, negative moves up
	assign floor_top  = coord_t'(`FLOOR_Y) - size;
	assign over_floor = (pos.x < `PIT_X_LO) || (pos.x > `PIT_X_HI);

	always_comb
	begin
		pos_next        = pos;
		vel_next        = vel;
		on_ground_next  = 1'b0;
		is_walking_next = 1'b0;
		walk_count_next = walk_count;
		direction_next  = direction;
		if (!alive)
		begin
			walk_count_next = '0;
			if (pos.y <= `Y_LIMIT)   // park once off screen until respawn
			begin
				pos_next.y = y_step;
				if (ticks.walk_tick)
					vel_next = hop_step(vel);
			end
		end
		else
		begin
			// sideways walk, stays inside the screen
			if (keys.left && !keys.right)
			begin
				direction_next = 1'b0;
				if (pos.x >= `HALF_W + `X_STEP)
					pos_next.x = pos.x - STEP;
			end
			else if (keys.right && !keys.left)
			begin
				direction_next = 1'b1;
				if (pos.x + `X_STEP + `HALF_W <= `X_LIMIT)
					pos_next.x = pos.x + STEP;
			end

			if (events.bounce)                  // stomp beats everything
				vel_next = vel_t'(`BOUNCE_VEL);
			else if (keys.up && on_ground)
				vel_next = vel_t'(`JUMP_VEL);
			else if (ticks.grav_tick)
				vel_next = fall_step(vel);

			pos_next.y = y_step;
			// land when the feet reach the floor from above, never in the pit
			if (over_floor && !vel_next[`VEL_W-1] && pos.y < `FLOOR_Y && y_step >= floor_top)
			begin
				pos_next.y     = floor_top;
				vel_next       = '0;
				on_ground_next = 1'b1;
			end

			is_walking_next = on_ground && (keys.left ^ keys.right);
			if (ticks.walk_tick)
			begin
				if (!is_walking || walk_count == 2'd2)  // three frames, 0 1 2
					walk_count_next = '0;
				else
					walk_count_next = walk_count + 2'd1;
			end
		end
	end

	always_ff @(posedge reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			pos        <= START;
			vel        <= '0;
			on_ground  <= 1'b0;
			is_walking <= 1'b0;
			walk_count <= '0;
			direction  <= 1'b1;
		end
		else if (run || respawn)   // back to the start point
		begin
			pos        <= START;
			vel        <= '0;
			on_ground  <= 1'b0;
			is_walking <= 1'b0;
			walk_count <= '0;
			direction  <= 1'b1;
		end
		else
		begin
			pos        <= pos_next;
			vel        <= vel_next;
			on_ground  <= on_ground_next;
			is_walking <= is_walking_next;
			walk_count <= walk_count_next;
			direction  <= direction_next;
		end
	end

endmodule

/* logic/life_ctrl.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module life_ctrl
(
	input  logic                   reset,      // frame strobe
	input  logic                   frame_clk,  // async clear
	input  logic                   run,
	input  character_pkg::ticks_t  ticks,
	input  character_pkg::events_t events,
	input  character_pkg::point_t  pos,
	output logic [1:0]             health,     // 0 dead, 1 small, 2 big
	output character_pkg::coord_t  size,
	output logic [1:0]             lives,
	output logic                   respawn,
	output logic                   alive
);
	import character_pkg::*;

	localparam coord_t SMALL = coord_t'(`SIZE_SMALL);
	localparam coord_t BIG   = coord_t'(`SIZE_BIG);

	logic       fell;       // centre dropped below the screen
	logic [1:0] lives_up;   // one more life, held at 3

	assign alive    = health != 2'd0;
	assign fell     = pos.y > `Y_LIMIT;
	assign lives_up = (lives == 2'd3) ? lives : lives + 2'd1;

	always_ff @(posedge reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			health  <= 2'd1;
			size    <= SMALL;
			lives   <= 2'(`LIVES_INIT);
			respawn <= 1'b0;
		end
		else if (run || respawn)   // fresh body, lives carry over
		begin
			health  <= 2'd1;
			size    <= SMALL;
			respawn <= 1'b0;
		end
		else if (alive)
		begin
			if (fell)                  // falling out always kills
			begin
				health <= 2'd0;
				size   <= SMALL;
			end
			else if (events.hurt)
			begin
				health <= health - 2'd1;
				size   <= SMALL;        // big body is lost on any hit
			end
			else if (events.power_up)
			begin
				health <= 2'd2;
				size   <= BIG;
			end
			if (events.extra_life)
				lives <= lives_up;
		end
		else if (ticks.respawn_tick && lives != 2'd0)
		begin
			lives   <= lives - 2'd1;   // spend a life on the way back
			respawn <= 1'b1;
		end
	end

endmodule

/* logic/character_top.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module character_top
(
	input  logic                  reset,       // frame strobe
	input  logic                  frame_clk,   // async clear, active high
	input  logic                  run,         // restart, keeps lives
	input  character_pkg::keys_t  keys,
	input  character_pkg::point_t objects [`N_OBJ],
	output character_pkg::point_t pos,
	output logic                  on_ground,
	output logic                  is_walking,
	output logic [1:0]            walk_count,
	output logic                  direction,
	output logic [1:0]            health,
	output character_pkg::coord_t size,
	output logic [1:0]            lives
);
	import character_pkg::*;

	box_t     char_box;
	box_t     obj_box [`N_OBJ];
	contact_t contact [`N_OBJ];
	events_t  events;
	ticks_t   ticks;
	logic     alive;
	logic     respawn;

	hitbox_builder u_hitbox (
		.pos      (pos),
		.size     (size),
		.objects  (objects),
		.char_box (char_box),
		.obj_box  (obj_box)
	);

	// one overlap test per object
	for (genvar i = 0; i < `N_OBJ; i++)
	begin : g_obj
		object_contact u_contact (
			.char_box (char_box),
			.obj_box  (obj_box[i]),
			.airborne (~on_ground),
			.contact  (contact[i])
		);
	end

	contact_resolver u_resolver (
		.contact   (contact),
		.on_ground (on_ground),
		.alive     (alive),
		.events    (events)
	);

	frame_timer u_timer (
		.reset     (reset),
		.frame_clk (frame_clk),
		.run       (run),
		.respawn   (respawn),
		.ticks     (ticks)
	);

	motion_ctrl u_motion (
		.reset      (reset),
		.frame_clk  (frame_clk),
		.run        (run),
		.respawn    (respawn),
		.keys       (keys),
		.ticks      (ticks),
		.events     (events),
		.alive      (alive),
		.size       (size),
		.pos        (pos),
		.vel        (),
		.on_ground  (on_ground),
		.is_walking (is_walking),
		.walk_count (walk_count),
		.direction  (direction)
	);

	life_ctrl u_life (
		.reset     (reset),
		.frame_clk (frame_clk),
		.run       (run),
		.ticks     (ticks),
		.events    (events),
		.pos       (pos),
		.health    (health),
		.size      (size),
		.lives     (lives),
		.respawn   (respawn),
		.alive     (alive)
	);

endmodule

/* tb/character_checker.sv */
`timescale 1ns/10ps

module character_checker
(
	input logic       reset,       // frame clock of the DUT
	input logic       frame_clk,   // async reset of the DUT
	input logic [1:0] walk_count,
	input logic [1:0] lives,
	input logic [1:0] health,
	input logic       respawn
);

	int assert_fails = 0;   // failed assertions so far

	// walk animation has three frames, 0 1 2
	walk_count_range: assert property (@(posedge reset) disable iff (frame_clk)
		walk_count != 2'd3)
	else
	begin
		assert_fails++;
		$error("walk_count reached 3");
	end

	// a life is only spent together with the respawn strobe
	lives_drop_on_respawn: assert property (@(posedge reset) disable iff (frame_clk)
		(lives < $past(lives)) |-> respawn)
	else
	begin
		assert_fails++;
		$error("lives dropped without a respawn");
	end

	health_range: assert property (@(posedge reset) disable iff (frame_clk)
		health != 2'd3)   // 2 is the big body
	else
	begin
		assert_fails++;
		$error("health reached 3");
	end

endmodule

bind character_top character_checker u_checker (
	.reset      (reset),
	.frame_clk  (frame_clk),
	.walk_count (walk_count),
	.lives      (lives),
	.health     (health),
	.respawn    (respawn)
);

/* tb/character_tb.sv */
`timescale 1ns/10ps
`include "character_defines.svh"

module character_tb;
	import character_pkg::*;

	localparam int NO_OBJ = `N_OBJ;                   // row moves no object onto the path
	localparam int XS     = `X_START;
	localparam int ST     = `X_STEP;
	localparam int GY     = `FLOOR_Y - `SIZE_SMALL;   // centre y of a small body on the floor

	localparam keys_t K_NONE  = 3'b000;
	localparam keys_t K_UP    = 3'b100;
	localparam keys_t K_LEFT  = 3'b010;
	localparam keys_t K_RIGHT = 3'b001;

	// one line of the stimulus table
	typedef struct packed {
		keys_t      keys;
		logic [2:0] obj_sel;       // object placed by this row
		point_t     obj_pos;
		logic       run;
		logic       until_start;   // end the row early once back at the start point
		logic [9:0] frames;
		logic [1:0] exp_health;
		logic [1:0] exp_lives;
		coord_t     exp_size;
		coord_t     exp_x;
		logic       exp_dir;
		logic [1:0] exp_gnd;       // 2 means don't care
	} row_t;

	logic       reset;        // frame clock
	logic       frame_clk;    // async reset, active high
	logic       run;
	keys_t      keys;
	point_t     objects [`N_OBJ];
	point_t     pos;
	logic       on_ground;
	logic       is_walking;
	logic [1:0] walk_count;
	logic       direction;
	logic [1:0] health;
	coord_t     size;
	logic [1:0] lives;

	row_t rows [$];
	int   checks       = 0;
	int   errors       = 0;
	int   cur_row      = -1;   // -1 while checking the reset state
	int   cycles       = 0;
	int   cycle_limit  = 0;
	int   total_frames = 0;

	character_top u_dut (
		.reset      (reset),
		.frame_clk  (frame_clk),
		.run        (run),
		.keys       (keys),
		.objects    (objects),
		.pos        (pos),
		.on_ground  (on_ground),
		.is_walking (is_walking),
		.walk_count (walk_count),
		.direction  (direction),
		.health     (health),
		.size       (size),
		.lives      (lives)
	);

	initial
	begin
		reset = 1'b0;
		forever #2 reset = ~reset;   // 4 ns frame
	end

	always @(posedge reset)
		cycles <= cycles + 1;

	// watchdog on the frame count
	initial
	begin
		wait (cycle_limit != 0 && cycles >= cycle_limit);
		$display("timeout: table not finished after %0d frames", cycles);
		$display("checks %0d, errors %0d", checks, errors);
		$display("TEST FAIL");
		$finish;
	end

	task automatic add_row(input keys_t k, input int obj, input int ox, input int oy,
		input bit rst_run, input int frames, input bit until_start,
		input int h, input int l, input int s, input int x, input bit dir, input int gnd);
		row_t r;
		r.keys        = k;
		r.obj_sel     = 3'(obj);
		r.obj_pos     = '{x: coord_t'(ox), y: coord_t'(oy)};
		r.run         = rst_run;
		r.until_start = until_start;
		r.frames      = 10'(frames);
		r.exp_health  = 2'(h);
		r.exp_lives   = 2'(l);
		r.exp_size    = coord_t'(s);
		r.exp_x       = coord_t'(x);
		r.exp_dir     = dir;
		r.exp_gnd     = 2'(gnd);
		rows.push_back(r);
		total_frames += frames;
	endtask

	// objects not in use sit at the right edge, off the walking path
	task automatic park_objects();
		int i;
		for (i = 0; i < `N_OBJ; i++)
			objects[i] = '{x: coord_t'(600), y: coord_t'(60 + 40 * i)};
	endtask

	task automatic apply_row(input row_t r);
		keys = r.keys;
		run  = r.run;
		park_objects();
		if (r.obj_sel < NO_OBJ)
			objects[r.obj_sel] = r.obj_pos;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s row %0d: got 0x%0h, expected 0x%0h", name, cur_row, got, exp);
		end
	endtask

	task automatic check_row(input row_t r);
		check_value("health", health, r.exp_health);
		check_value("lives", lives, r.exp_lives);
		check_value("size", size, r.exp_size);
		check_value("pos.x", pos.x, r.exp_x);
		check_value("direction", direction, r.exp_dir);
		if (r.exp_gnd != 2'd2)
			check_value("on_ground", on_ground, r.exp_gnd);
	endtask

	initial
	begin
		row_t r;
		int   n;
		int   f;
		int   afails;
		//      keys     object      ox          oy  run frm  wait h  l  size  x           dir gnd
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, 20,   0, 1, 2, `SIZE_SMALL, XS, 1, 1);
		add_row(K_RIGHT, NO_OBJ,     0,          0,  0, 10,   0, 1, 2, `SIZE_SMALL, XS+10*ST, 1, 1);
		add_row(K_LEFT,  NO_OBJ,     0,          0,  0, 4,    0, 1, 2, `SIZE_SMALL, XS+6*ST, 0, 1);
		add_row(K_NONE,  ROLE_RED,   XS+6*ST,    GY, 0, 1,    0, 2, 2, `SIZE_BIG, XS+6*ST, 0, 1);
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, 3,    0, 2, 2, `SIZE_BIG, XS+6*ST, 0, 1);
		add_row(K_NONE,  ROLE_ENEMY, XS+6*ST+15, GY, 0, 1,    0, 1, 2, `SIZE_SMALL, XS+6*ST, 0, 2);
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, 8,    0, 1, 2, `SIZE_SMALL, XS+6*ST, 0, 1);
		add_row(K_NONE,  ROLE_GREEN, XS+6*ST,    GY, 0, 1,    0, 1, 3, `SIZE_SMALL, XS+6*ST, 0, 1);
		// into the middle of the pit, then fall out of the screen
		add_row(K_RIGHT, NO_OBJ,     0,          0,  0, 134,  0, 1, 3, `SIZE_SMALL, 320, 1, 0);
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, 30,   0, 0, 3, `SIZE_SMALL, 320, 1, 0);
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, `DELAY_WRAP+2, 1, 1, 2, `SIZE_SMALL, XS, 1, 0);
		// upgrade, then a restart keeps the lives
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, 20,   0, 1, 2, `SIZE_SMALL, XS, 1, 1);
		add_row(K_NONE,  ROLE_RED,   XS,         GY, 0, 1,    0, 2, 2, `SIZE_BIG, XS, 1, 1);
		add_row(K_RIGHT, NO_OBJ,     0,          0,  0, 10,   0, 2, 2, `SIZE_BIG, XS+10*ST, 1, 1);
		add_row(K_NONE,  NO_OBJ,     0,          0,  1, 1,    0, 1, 2, `SIZE_SMALL, XS, 1, 0);
		add_row(K_NONE,  NO_OBJ,     0,          0,  0, 20,   0, 1, 2, `SIZE_SMALL, XS, 1, 1);
		add_row(K_UP,    NO_OBJ,     0,          0,  0, 1,    0, 1, 2, `SIZE_SMALL, XS, 1, 0);
		cycle_limit = 2 * total_frames;

		frame_clk = 1'b1;
		run       = 1'b0;
		keys      = K_NONE;
		park_objects();
		repeat (16) @(posedge reset);
		#1;
		frame_clk = 1'b0;

		// reset state
		check_value("pos.x", pos.x, `X_START);
		check_value("pos.y", pos.y, `Y_START);
		check_value("on_ground", on_ground, 0);
		check_value("is_walking", is_walking, 0);
		check_value("walk_count", walk_count, 0);
		check_value("direction", direction, 1);
		check_value("health", health, 1);
		check_value("size", size, `SIZE_SMALL);
		check_value("lives", lives, `LIVES_INIT);

		for (n = 0; n < rows.size(); n++)
		begin
			r       = rows[n];
			cur_row = n;
			apply_row(r);                // 1 ns after the edge
			for (f = 0; f < r.frames; f++)
			begin
				@(posedge reset);
				#1;
				if (r.until_start && pos.x == `X_START && pos.y == `Y_START)
					break;
			end
			if (r.until_start && f == r.frames)
			begin
				errors++;
				$display("row %0d: character did not return to the start point", n);
			end
			check_row(r);
		end

		afails = u_dut.u_checker.assert_fails;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
		if (errors == 0 && afails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* character_top.f */
+incdir+include
logic/character_pkg.sv
logic/hitbox_builder.sv
logic/object_contact.sv
logic/contact_resolver.sv
logic/frame_timer.sv
logic/motion_ctrl.sv
logic/life_ctrl.sv
logic/character_top.sv
tb/character_checker.sv
tb/character_tb.sv

/* Bender.yml */
package:
  name: character_top

sources:
  - include_dirs:
      - include
    files:
      - logic/character_pkg.sv
      - logic/hitbox_builder.sv
      - logic/object_contact.sv
      - logic/contact_resolver.sv
      - logic/frame_timer.sv
      - logic/motion_ctrl.sv
      - logic/life_ctrl.sv
      - logic/character_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/character_checker.sv
      - tb/character_tb.sv
